//--- demux_consts.svh
/* fixed sizing constants of the read-channel demultiplexer
   port count, bus field widths and in-flight counter size */

`ifndef DEMUX_CONSTS_SVH
`define DEMUX_CONSTS_SVH

// manager side
`define DMX_NUM_PORTS 4
// enough bits to name any of the manager ports
`define DMX_SEL_WIDTH 2

// AXI ID handling
`define DMX_ID_WIDTH 4
// only the low ID bits pick a counter, so four counters
`define DMX_LOOK_BITS 2
// a counter saturates at 3 reads in flight per lookup ID
`define DMX_CNT_WIDTH 2

// AR and R payload
`define DMX_ADDR_WIDTH 32
`define DMX_DATA_WIDTH 32
// beats per burst are len + 1
`define DMX_LEN_WIDTH 8

`endif

//--- demux_width_pkg.sv
/* vector types for every field width that carries a meaning
   IDs, counter index, port select, payload, burst length and counts */

`include "demux_consts.svh"

package demux_width_pkg;

  // full AXI ID as seen on both sides
  typedef logic [`DMX_ID_WIDTH-1:0]   axi_id_t;

  // low ID bits used to index the in-flight table
  typedef logic [`DMX_LOOK_BITS-1:0]  look_id_t;

  // manager port number
  typedef logic [`DMX_SEL_WIDTH-1:0]  port_sel_t;

  // payload fields, forwarded untouched
  typedef logic [`DMX_ADDR_WIDTH-1:0] addr_t;
  typedef logic [`DMX_DATA_WIDTH-1:0] data_t;
  typedef logic [`DMX_LEN_WIDTH-1:0]  len_t;

  // in-flight read count of one lookup ID
  typedef logic [`DMX_CNT_WIDTH-1:0]  cnt_t;

endpackage

//--- demux_ctrl_pkg.sv
/* state encodings for the AR admission gate and the R merge arbiter */

package demux_ctrl_pkg;

  // AR gate
  // IDLE   deciding on the current request every cycle
  // LOCKED valid is held on the chosen port until it is taken
  typedef enum logic {
    IDLE   = 1'b0,
    LOCKED = 1'b1
  } gate_state_e;

  // R arbiter
  // FREE  a new grant may be picked
  // BURST grant held on one port until its last beat moves
  typedef enum logic {
    FREE  = 1'b0,
    BURST = 1'b1
  } arb_state_e;

endpackage

//--- rd_id_table.sv
/* per-ID in-flight read counters with the port each ID was last sent to
   lookup of select and occupancy, plus a table-wide full flag */

`timescale 1ns/1ps
`include "demux_consts.svh"

module rd_id_table (
  input  logic                        clk_i,
  input  logic                        rst_i,
  // lookup for the request waiting at the gate
  input  demux_width_pkg::look_id_t   lookup_id_i,
  output demux_width_pkg::port_sel_t  lookup_sel_o,
  output logic                        occupied_o,
  output logic                        full_o,
  // push on every accepted AR
  input  logic                        push_i,
  input  demux_width_pkg::look_id_t   push_id_i,
  input  demux_width_pkg::port_sel_t  push_sel_i,
  // pop on every last R beat handed upstream
  input  logic                        pop_i,
  input  demux_width_pkg::look_id_t   pop_id_i
);

  localparam int NUM_CNT = 1 << `DMX_LOOK_BITS;

  demux_width_pkg::cnt_t      cnt_q [NUM_CNT];
  demux_width_pkg::cnt_t      cnt_d [NUM_CNT];
  demux_width_pkg::port_sel_t sel_q [NUM_CNT];
  logic [NUM_CNT-1:0]         push_en;
  logic [NUM_CNT-1:0]         pop_en;
  logic [NUM_CNT-1:0]         cnt_full;

  //--------------------------------------------------
  // lookup
  //--------------------------------------------------
  // stored select is only meaningful while occupied
  assign lookup_sel_o = sel_q[lookup_id_i];
  assign occupied_o   = (cnt_q[lookup_id_i] != '0);
  // one saturated counter blocks all admissions
  assign full_o       = |cnt_full;

  //--------------------------------------------------
  // counter update
  //--------------------------------------------------
  always_comb begin
    for (int i = 0; i < NUM_CNT; i++) begin
      push_en[i]  = push_i && (push_id_i == demux_width_pkg::look_id_t'(i));
      pop_en[i]   = pop_i && (pop_id_i == demux_width_pkg::look_id_t'(i));
      cnt_full[i] = &cnt_q[i];
      case ({push_en[i], pop_en[i]})
        // new read leaves for a manager
        2'b10: cnt_d[i] = cnt_q[i] + 1'b1;
        // burst completed upstream
        2'b01: cnt_d[i] = cnt_q[i] - 1'b1;
        // push and pop cancel, or nothing happens
        default: cnt_d[i] = cnt_q[i];
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 0; i < NUM_CNT; i++) begin
        cnt_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < NUM_CNT; i++) begin
        cnt_q[i] <= cnt_d[i];
      end
    end
  end

  // select follows the latest push of that ID
  // all pushes of a live ID name the same port anyway
  always_ff @(posedge clk_i) begin
    for (int i = 0; i < NUM_CNT; i++) begin
      if (push_en[i]) begin
        sel_q[i] <= push_sel_i;
      end
    end
  end

endmodule

//--- ar_route_gate.sv
/* AR admission against the ID table, valid lock and steering
   of the request onto the selected manager port */

`timescale 1ns/1ps
`include "demux_consts.svh"

module ar_route_gate (
  input  logic                        clk_i,
  input  logic                        rst_i,
  // subordinate AR handshake and routing fields
  input  logic                        ar_valid_i,
  output logic                        ar_ready_o,
  input  demux_width_pkg::axi_id_t    ar_id_i,
  input  demux_width_pkg::port_sel_t  ar_sel_i,
  // manager AR handshakes
  output logic [`DMX_NUM_PORTS-1:0]   mst_ar_valid_o,
  input  logic [`DMX_NUM_PORTS-1:0]   mst_ar_ready_i,
  // ID table lookup
  output demux_width_pkg::look_id_t   lookup_id_o,
  input  demux_width_pkg::port_sel_t  lookup_sel_i,
  input  logic                        occupied_i,
  input  logic                        full_i,
  // ID table push
  output logic                        push_o,
  output demux_width_pkg::look_id_t   push_id_o,
  output demux_width_pkg::port_sel_t  push_sel_o
);

  demux_ctrl_pkg::gate_state_e state_q;
  demux_ctrl_pkg::gate_state_e state_d;
  logic                        admit;
  logic                        fwd_valid;
  logic                        sel_ready;

  //--------------------------------------------------
  // admission
  //--------------------------------------------------
  assign lookup_id_o = ar_id_i[`DMX_LOOK_BITS-1:0];

  // same ID may only go out again to the port it already uses
  assign admit = !full_i && (!occupied_i || (lookup_sel_i == ar_sel_i));

  // once locked the table is ignored, valid must not drop
  assign fwd_valid = (state_q == demux_ctrl_pkg::LOCKED) || (ar_valid_i && admit);

  // ready of the addressed port only
  assign sel_ready = mst_ar_ready_i[ar_sel_i];

  assign ar_ready_o = fwd_valid && sel_ready;

  // steer valid to exactly one port
  always_comb begin
    for (int i = 0; i < `DMX_NUM_PORTS; i++) begin
      mst_ar_valid_o[i] = fwd_valid && (ar_sel_i == demux_width_pkg::port_sel_t'(i));
    end
  end

  //--------------------------------------------------
  // table push on the transfer
  //--------------------------------------------------
  assign push_o     = fwd_valid && sel_ready;
  assign push_id_o  = ar_id_i[`DMX_LOOK_BITS-1:0];
  assign push_sel_o = ar_sel_i;

  //--------------------------------------------------
  // valid lock
  //--------------------------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      demux_ctrl_pkg::IDLE: begin
        // decision made but the port is busy
        if (fwd_valid && !sel_ready) begin
          state_d = demux_ctrl_pkg::LOCKED;
        end
      end
      demux_ctrl_pkg::LOCKED: begin
        if (sel_ready) begin
          state_d = demux_ctrl_pkg::IDLE;
        end
      end
      default: state_d = demux_ctrl_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= demux_ctrl_pkg::IDLE;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

//--- r_resp_arbiter.sv
/* round-robin merge of the manager R channels onto the subordinate port
   grant held for a whole burst and for any stalled beat */

`timescale 1ns/1ps
`include "demux_consts.svh"

module r_resp_arbiter (
  input  logic                                             clk_i,
  input  logic                                             rst_i,
  // manager R channels
  input  logic [`DMX_NUM_PORTS-1:0]                        mst_r_valid_i,
  output logic [`DMX_NUM_PORTS-1:0]                        mst_r_ready_o,
  input  demux_width_pkg::axi_id_t [`DMX_NUM_PORTS-1:0]    mst_r_id_i,
  input  demux_width_pkg::data_t   [`DMX_NUM_PORTS-1:0]    mst_r_data_i,
  input  logic [`DMX_NUM_PORTS-1:0]                        mst_r_last_i,
  // subordinate R channel
  output logic                                             r_valid_o,
  input  logic                                             r_ready_i,
  output demux_width_pkg::axi_id_t                         r_id_o,
  output demux_width_pkg::data_t                           r_data_o,
  output logic                                             r_last_o,
  // completion towards the ID table
  output logic                                             pop_o,
  output demux_width_pkg::look_id_t                        pop_id_o
);

  demux_ctrl_pkg::arb_state_e state_q;
  demux_ctrl_pkg::arb_state_e state_d;
  demux_width_pkg::port_sel_t ptr_q;
  demux_width_pkg::port_sel_t gnt_q;
  demux_width_pkg::port_sel_t pick;
  demux_width_pkg::port_sel_t rr_cand;
  demux_width_pkg::port_sel_t gnt;
  logic                       found;
  logic                       last_xfer;

  //--------------------------------------------------
  // round-robin pick
  //--------------------------------------------------
  // search starts at the pointer, first valid port wins
  always_comb begin
    pick    = ptr_q;
    found   = 1'b0;
    rr_cand = ptr_q;
    for (int k = 0; k < `DMX_NUM_PORTS; k++) begin
      rr_cand = demux_width_pkg::port_sel_t'(ptr_q + k);
      if (!found && mst_r_valid_i[rr_cand]) begin
        pick  = rr_cand;
        found = 1'b1;
      end
    end
  end

  // held grant wins while inside a burst or a stalled beat
  assign gnt = (state_q == demux_ctrl_pkg::BURST) ? gnt_q : pick;

  //--------------------------------------------------
  // R mux
  //--------------------------------------------------
  assign r_valid_o = mst_r_valid_i[gnt];
  assign r_id_o    = mst_r_id_i[gnt];
  assign r_data_o  = mst_r_data_i[gnt];
  assign r_last_o  = mst_r_last_i[gnt];

  // only the granted port sees ready, others keep their beats
  always_comb begin
    for (int i = 0; i < `DMX_NUM_PORTS; i++) begin
      mst_r_ready_o[i] = r_valid_o && r_ready_i &&
                         (gnt == demux_width_pkg::port_sel_t'(i));
    end
  end

  assign last_xfer = r_valid_o && r_ready_i && r_last_o;

  // burst done upstream, free the ID slot
  assign pop_o    = last_xfer;
  assign pop_id_o = r_id_o[`DMX_LOOK_BITS-1:0];

  //--------------------------------------------------
  // burst lock and pointer
  //--------------------------------------------------
  always_comb begin
    state_d = state_q;
    if (r_valid_o) begin
      // anything short of a finished last beat keeps the port
      state_d = last_xfer ? demux_ctrl_pkg::FREE : demux_ctrl_pkg::BURST;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= demux_ctrl_pkg::FREE;
      ptr_q   <= '0;
      gnt_q   <= '0;
    end else begin
      state_q <= state_d;
      gnt_q   <= gnt;
      // next search begins just after the port that finished
      if (last_xfer) begin
        ptr_q <= gnt + 1'b1;
      end
    end
  end

endmodule

//--- rd_demux_top.sv
/* read-channel AXI demux top, one subordinate AR/R port to four managers
   gate, ID table and R arbiter wired together */

`timescale 1ns/1ps
`include "demux_consts.svh"

module rd_demux_top (
  input  logic                                             clk_i,
  input  logic                                             rst_i,
  // subordinate AR
  input  logic                                             ar_valid_i,
  output logic                                             ar_ready_o,
  input  demux_width_pkg::axi_id_t                         ar_id_i,
  input  demux_width_pkg::addr_t                           ar_addr_i,
  input  demux_width_pkg::len_t                            ar_len_i,
  input  demux_width_pkg::port_sel_t                       ar_sel_i,
  // subordinate R
  output logic                                             r_valid_o,
  input  logic                                             r_ready_i,
  output demux_width_pkg::axi_id_t                         r_id_o,
  output demux_width_pkg::data_t                           r_data_o,
  output logic                                             r_last_o,
  // manager AR, fields shared by all ports
  output logic [`DMX_NUM_PORTS-1:0]                        mst_ar_valid_o,
  input  logic [`DMX_NUM_PORTS-1:0]                        mst_ar_ready_i,
  output demux_width_pkg::axi_id_t                         mst_ar_id_o,
  output demux_width_pkg::addr_t                           mst_ar_addr_o,
  output demux_width_pkg::len_t                            mst_ar_len_o,
  // manager R
  input  logic [`DMX_NUM_PORTS-1:0]                        mst_r_valid_i,
  output logic [`DMX_NUM_PORTS-1:0]                        mst_r_ready_o,
  input  demux_width_pkg::axi_id_t [`DMX_NUM_PORTS-1:0]    mst_r_id_i,
  input  demux_width_pkg::data_t   [`DMX_NUM_PORTS-1:0]    mst_r_data_i,
  input  logic [`DMX_NUM_PORTS-1:0]                        mst_r_last_i
);

  // gate to table
  demux_width_pkg::look_id_t  lookup_id;
  demux_width_pkg::port_sel_t lookup_sel;
  logic                       occupied;
  logic                       full;
  logic                       push;
  demux_width_pkg::look_id_t  push_id;
  demux_width_pkg::port_sel_t push_sel;
  // arbiter to table
  logic                       pop;
  demux_width_pkg::look_id_t  pop_id;

  // AR payload goes straight through, only valid is steered
  assign mst_ar_id_o   = ar_id_i;
  assign mst_ar_addr_o = ar_addr_i;
  assign mst_ar_len_o  = ar_len_i;

  ar_route_gate u_gate (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .ar_valid_i     (ar_valid_i),
    .ar_ready_o     (ar_ready_o),
    .ar_id_i        (ar_id_i),
    .ar_sel_i       (ar_sel_i),
    .mst_ar_valid_o (mst_ar_valid_o),
    .mst_ar_ready_i (mst_ar_ready_i),
    .lookup_id_o    (lookup_id),
    .lookup_sel_i   (lookup_sel),
    .occupied_i     (occupied),
    .full_i         (full),
    .push_o         (push),
    .push_id_o      (push_id),
    .push_sel_o     (push_sel)
  );

  rd_id_table u_table (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .lookup_id_i  (lookup_id),
    .lookup_sel_o (lookup_sel),
    .occupied_o   (occupied),
    .full_o       (full),
    .push_i       (push),
    .push_id_i    (push_id),
    .push_sel_i   (push_sel),
    .pop_i        (pop),
    .pop_id_i     (pop_id)
  );

  r_resp_arbiter u_arb (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .mst_r_valid_i (mst_r_valid_i),
    .mst_r_ready_o (mst_r_ready_o),
    .mst_r_id_i    (mst_r_id_i),
    .mst_r_data_i  (mst_r_data_i),
    .mst_r_last_i  (mst_r_last_i),
    .r_valid_o     (r_valid_o),
    .r_ready_i     (r_ready_i),
    .r_id_o        (r_id_o),
    .r_data_o      (r_data_o),
    .r_last_o      (r_last_o),
    .pop_o         (pop),
    .pop_id_o      (pop_id)
  );

endmodule

//--- tb_clk_gen.sv
/* testbench clock, 40 ns period, and power-on reset */

`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_o
);

  initial begin
    clk_o = 1'b0;
    forever #20 clk_o = ~clk_o;
  end

  // reset spans the first three rising edges
  initial begin
    rst_o = 1'b1;
    repeat (3) @(posedge clk_o);
    #1;
    rst_o = 1'b0;
  end

endmodule

//--- rd_demux_assert.sv
/* concurrent handshake checks on the demux top
   AR hold and stability, single AR target, R hold until ready */

`timescale 1ns/1ps
`include "demux_consts.svh"

module rd_demux_assert (
  input logic                        clk_i,
  input logic                        rst_i,
  // manager AR side
  input logic [`DMX_NUM_PORTS-1:0]   ar_valid_i,
  input logic [`DMX_NUM_PORTS-1:0]   ar_ready_i,
  input demux_width_pkg::axi_id_t    ar_id_i,
  input demux_width_pkg::addr_t      ar_addr_i,
  input demux_width_pkg::len_t       ar_len_i,
  // subordinate R side
  input logic                        r_valid_i,
  input logic                        r_ready_i,
  input demux_width_pkg::axi_id_t    r_id_i,
  input demux_width_pkg::data_t      r_data_i,
  input logic                        r_last_i
);

  // read back by the testbench at the end of the run
  int unsigned fail_cnt = 0;

  // a waiting manager request keeps its port and its fields
  property ar_hold_p;
    @(posedge clk_i) disable iff (rst_i)
      (|(ar_valid_i & ~ar_ready_i)) |=>
        (ar_valid_i == $past(ar_valid_i)) && $stable(ar_id_i) &&
        $stable(ar_addr_i) && $stable(ar_len_i);
  endproperty

  // a stalled R beat stays up and unchanged
  property r_hold_p;
    @(posedge clk_i) disable iff (rst_i)
      (r_valid_i && !r_ready_i) |=>
        r_valid_i && $stable(r_id_i) && $stable(r_data_i) && $stable(r_last_i);
  endproperty

  ar_hold_a: assert property (ar_hold_p) else begin
    fail_cnt++;
    $error("manager AR request dropped or changed before ready");
  end

  // never more than one manager addressed
  ar_onehot_a: assert property (@(posedge clk_i) disable iff (rst_i) $onehot0(ar_valid_i))
    else begin
      fail_cnt++;
      $error("more than one manager AR valid high");
    end

  r_hold_a: assert property (r_hold_p) else begin
    fail_cnt++;
    $error("subordinate R beat dropped or changed before ready");
  end

endmodule

//--- rd_demux_tb.sv
/* read demux testbench with manager responder models, reference beat rule,
   compare process, directed and random tests and a watchdog */

`timescale 1ns/1ps
`include "demux_consts.svh"

module rd_demux_tb;

  localparam int NUM_RAND  = 40;
  // ten directed plus the random requests with one AR and up to four beats each
  localparam int NUM_XFERS = (NUM_RAND + 10) * 5;

  logic                                           clk;
  logic                                           rst;
  logic                                           ar_valid;
  logic                                           ar_ready;
  demux_width_pkg::axi_id_t                       ar_id;
  demux_width_pkg::addr_t                         ar_addr;
  demux_width_pkg::len_t                          ar_len;
  demux_width_pkg::port_sel_t                     ar_sel;
  logic                                           r_valid;
  logic                                           r_ready;
  demux_width_pkg::axi_id_t                       r_id;
  demux_width_pkg::data_t                         r_data;
  logic                                           r_last;
  logic [`DMX_NUM_PORTS-1:0]                      mst_ar_valid;
  logic [`DMX_NUM_PORTS-1:0]                      mst_ar_ready;
  demux_width_pkg::axi_id_t                       mst_ar_id;
  demux_width_pkg::addr_t                         mst_ar_addr;
  demux_width_pkg::len_t                          mst_ar_len;
  logic [`DMX_NUM_PORTS-1:0]                      mst_r_valid;
  logic [`DMX_NUM_PORTS-1:0]                      mst_r_ready;
  demux_width_pkg::axi_id_t [`DMX_NUM_PORTS-1:0]  mst_r_id;
  demux_width_pkg::data_t   [`DMX_NUM_PORTS-1:0]  mst_r_data;
  logic [`DMX_NUM_PORTS-1:0]                      mst_r_last;

  // run control and counts
  string       test_name;
  int          errors;
  int          checks;
  int          tests;
  int          err_mark;
  logic [3:0]  r_hold;
  logic        gaps_on;
  logic [31:0] stim_rng;
  logic [31:0] bus_rng;

  // expected bursts per full ID as {sel, len, addr}
  logic [41:0] exp_mem [16][4];
  int          exp_wr [16];
  int          exp_rd [16];
  int          exp_beat [16];
  int          bursts_issued;
  int          bursts_done;
  int          beats_due;
  int          beats_seen;
  logic        in_burst;
  demux_width_pkg::axi_id_t burst_id;

  // requests taken by each responder as {id, len, addr}
  logic [43:0] pend_mem [4][16];
  int          pend_wr [4];
  int          pend_rd [4];
  int          beat_no [4];

  tb_clk_gen u_clk (
    .clk_o (clk),
    .rst_o (rst)
  );

  rd_demux_top uut (
    .clk_i          (clk),
    .rst_i          (rst),
    .ar_valid_i     (ar_valid),
    .ar_ready_o     (ar_ready),
    .ar_id_i        (ar_id),
    .ar_addr_i      (ar_addr),
    .ar_len_i       (ar_len),
    .ar_sel_i       (ar_sel),
    .r_valid_o      (r_valid),
    .r_ready_i      (r_ready),
    .r_id_o         (r_id),
    .r_data_o       (r_data),
    .r_last_o       (r_last),
    .mst_ar_valid_o (mst_ar_valid),
    .mst_ar_ready_i (mst_ar_ready),
    .mst_ar_id_o    (mst_ar_id),
    .mst_ar_addr_o  (mst_ar_addr),
    .mst_ar_len_o   (mst_ar_len),
    .mst_r_valid_i  (mst_r_valid),
    .mst_r_ready_o  (mst_r_ready),
    .mst_r_id_i     (mst_r_id),
    .mst_r_data_i   (mst_r_data),
    .mst_r_last_i   (mst_r_last)
  );

  bind rd_demux_top rd_demux_assert u_assert (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .ar_valid_i (mst_ar_valid_o),
    .ar_ready_i (mst_ar_ready_i),
    .ar_id_i    (mst_ar_id_o),
    .ar_addr_i  (mst_ar_addr_o),
    .ar_len_i   (mst_ar_len_o),
    .r_valid_i  (r_valid_o),
    .r_ready_i  (r_ready_i),
    .r_id_i     (r_id_o),
    .r_data_i   (r_data_o),
    .r_last_i   (r_last_o)
  );

  //--------------------------------------------------
  // helpers
  //--------------------------------------------------
  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // port number xored into the top address byte plus the beat number
  function automatic demux_width_pkg::data_t expected_beat(
    input demux_width_pkg::addr_t     addr,
    input demux_width_pkg::port_sel_t port,
    input int                         beat
  );
    return (addr ^ (demux_width_pkg::data_t'(port) << 24)) + demux_width_pkg::data_t'(beat);
  endfunction

  task automatic check_value(input string what, input logic [31:0] want, input logic [31:0] got);
    checks++;
    assert (want === got) else begin
      errors++;
      $display("Mismatch in %s: %s expected %h actual %h", test_name, what, want, got);
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    checks++;
    assert (cond) else begin
      errors++;
      $display("Error in %s: %s", test_name, what);
    end
  endtask

  task automatic put_ar(
    input demux_width_pkg::axi_id_t   id,
    input demux_width_pkg::port_sel_t sel,
    input demux_width_pkg::addr_t     addr,
    input demux_width_pkg::len_t      len
  );
    ar_valid = 1'b1;
    ar_id    = id;
    ar_sel   = sel;
    ar_addr  = addr;
    ar_len   = len;
  endtask

  // returns 1 ns after the edge that took the request
  task automatic wait_ar_accept();
    @(posedge clk);
    while (!ar_ready) begin
      @(posedge clk);
    end
    #1;
    ar_valid = 1'b0;
  endtask

  task automatic drain();
    while (bursts_done != bursts_issued) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic end_test();
    tests++;
    $display("%s finished with %0d errors", test_name, errors - err_mark);
    err_mark = errors;
  endtask

  //--------------------------------------------------
  // compare process
  //--------------------------------------------------
  always @(posedge clk) begin : compare
    logic [41:0]            ent;
    demux_width_pkg::data_t want;
    logic                   want_last;
    int                     idx;
    if (!rst) begin
      // a request taken upstream must sit on its own port only
      if (ar_valid && ar_ready) begin
        idx = int'(ar_id);
        check_value("AR port valids", 32'(1) << ar_sel, 32'(mst_ar_valid));
        check_value("AR ID", 32'(ar_id), 32'(mst_ar_id));
        check_value("AR address", ar_addr, mst_ar_addr);
        check_value("AR length", 32'(ar_len), 32'(mst_ar_len));
        exp_mem[idx][exp_wr[idx] % 4] = {ar_sel, ar_len, ar_addr};
        exp_wr[idx]++;
        bursts_issued++;
        beats_due += int'(ar_len) + 1;
      end
      if (r_valid && r_ready) begin
        idx = int'(r_id);
        beats_seen++;
        // an open burst owns the R port
        if (in_burst) begin
          check_value("R ID inside a burst", 32'(burst_id), 32'(r_id));
        end
        if (exp_wr[idx] == exp_rd[idx]) begin
          check_true(1'b0, $sformatf("R beat with ID %0d and no read outstanding", idx));
        end else begin
          ent       = exp_mem[idx][exp_rd[idx] % 4];
          want      = expected_beat(ent[31:0], ent[41:40], exp_beat[idx]);
          want_last = (exp_beat[idx] == int'(ent[39:32]));
          check_value("R data", want, r_data);
          check_value("R last", 32'(want_last), 32'(r_last));
          if (want_last) begin
            exp_rd[idx]++;
            exp_beat[idx] = 0;
            bursts_done++;
          end else begin
            exp_beat[idx]++;
          end
        end
        in_burst = !r_last;
        burst_id = r_id;
      end
    end
  end

  //--------------------------------------------------
  // manager responders and subordinate R ready
  //--------------------------------------------------
  initial begin : bus_model
    logic [3:0]  took;
    logic [43:0] head;
    mst_ar_ready = '0;
    mst_r_valid  = '0;
    mst_r_id     = '0;
    mst_r_data   = '0;
    mst_r_last   = '0;
    r_ready      = 1'b0;
    bus_rng      = 32'd2;
    forever begin
      @(posedge clk);
      for (int p = 0; p < `DMX_NUM_PORTS; p++) begin
        took[p] = mst_r_valid[p] && mst_r_ready[p];
        if (!rst && mst_ar_valid[p] && mst_ar_ready[p]) begin
          pend_mem[p][pend_wr[p] % 16] = {mst_ar_id, mst_ar_len, mst_ar_addr};
          pend_wr[p]++;
        end
        // step through the burst and drop it after its last beat
        if (!rst && took[p]) begin
          head = pend_mem[p][pend_rd[p] % 16];
          if (beat_no[p] == int'(head[39:32])) begin
            pend_rd[p]++;
            beat_no[p] = 0;
          end else begin
            beat_no[p]++;
          end
        end
      end
      #1;
      for (int p = 0; p < `DMX_NUM_PORTS; p++) begin
        bus_rng = lcg_next(bus_rng);
        mst_ar_ready[p] = !gaps_on || (bus_rng[30:29] != 2'b00);
        head = pend_mem[p][pend_rd[p] % 16];
        // a beat still waiting for ready is left alone
        if (rst || !mst_r_valid[p] || took[p]) begin
          if (!rst && (pend_wr[p] != pend_rd[p]) && !r_hold[p] && (!gaps_on || bus_rng[28])) begin
            mst_r_valid[p] = 1'b1;
            mst_r_id[p]    = head[43:40];
            mst_r_data[p]  = {head[31:24] ^ 8'(p), head[23:0]} + 32'(beat_no[p]);
            mst_r_last[p]  = (beat_no[p] == int'(head[39:32]));
          end else begin
            mst_r_valid[p] = 1'b0;
          end
        end
      end
      bus_rng = lcg_next(bus_rng);
      r_ready = !gaps_on || (bus_rng[30:29] != 2'b00);
    end
  end

  //--------------------------------------------------
  // test sequence
  //--------------------------------------------------
  initial begin : main
    int done0;
    ar_valid  = 1'b0;
    ar_id     = '0;
    ar_addr   = '0;
    ar_len    = '0;
    ar_sel    = '0;
    r_hold    = '0;
    gaps_on   = 1'b0;
    in_burst  = 1'b0;
    stim_rng  = 32'd2;
    test_name = "reset";
    repeat (2) @(posedge clk);
    #1;
    check_value("manager AR valids in reset", 32'd0, 32'(mst_ar_valid));
    check_value("R valid in reset", 32'd0, 32'(r_valid));
    wait (!rst);
    @(posedge clk);
    #1;
    check_value("manager AR valids after reset", 32'd0, 32'(mst_ar_valid));
    check_value("R valid after reset", 32'd0, 32'(r_valid));
    end_test();

    // one burst per port with lengths of 1 to 4 beats
    test_name = "routing";
    for (int p = 0; p < `DMX_NUM_PORTS; p++) begin
      put_ar(4'(p + 8), 2'(p), 32'h1000_0000 * p + 32'h40, 8'(p));
      wait_ar_accept();
    end
    drain();
    end_test();

    // ID 5 is busy on port 0 so the same ID to port 2 must wait
    test_name = "ordering stall";
    r_hold[0] = 1'b1;
    put_ar(4'h5, 2'd0, 32'h0000_2000, 8'd1);
    wait_ar_accept();
    done0 = bursts_done;
    put_ar(4'h5, 2'd2, 32'h0000_3000, 8'd2);
    repeat (8) begin
      @(posedge clk);
      check_true(mst_ar_valid == '0, "same-ID read reached port 2 before port 0 finished");
    end
    #1;
    r_hold[0] = 1'b0;
    wait_ar_accept();
    check_true(bursts_done > done0, "same-ID read taken before the earlier burst ended");
    drain();
    end_test();

    // three reads of ID 2 fill its counter
    test_name = "counter full";
    r_hold[1] = 1'b1;
    for (int i = 0; i < 3; i++) begin
      put_ar(4'h2, 2'd1, 32'h0000_4000 + 32'h100 * i, 8'd0);
      wait_ar_accept();
    end
    done0 = bursts_done;
    put_ar(4'h2, 2'd1, 32'h0000_4400, 8'd0);
    repeat (8) begin
      @(posedge clk);
      check_true(mst_ar_valid == '0, "fourth read of a full ID was forwarded");
    end
    #1;
    r_hold[1] = 1'b0;
    wait_ar_accept();
    check_true(bursts_done > done0, "fourth read taken before any burst ended");
    drain();
    end_test();

    // random IDs, ports and lengths with ready gaps everywhere
    test_name = "random traffic";
    gaps_on = 1'b1;
    for (int n = 0; n < NUM_RAND; n++) begin
      stim_rng = lcg_next(stim_rng);
      put_ar(stim_rng[19:16], stim_rng[21:20], lcg_next(stim_rng), 8'(stim_rng[23:22]));
      wait_ar_accept();
    end
    drain();
    gaps_on = 1'b0;
    check_value("beats returned", beats_due, beats_seen);
    end_test();

    $display("summary: %0d tests, %0d checks, %0d errors, %0d assertion failures",
             tests, checks, errors, uut.u_assert.fail_cnt);
    if (errors == 0 && uut.u_assert.fail_cnt == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // bound by the worst case of 50 cycles per transfer
  initial begin : watchdog
    repeat (NUM_XFERS * 50) @(posedge clk);
    $display("watchdog expired after %0d cycles with tests still running", NUM_XFERS * 50);
    $display("TEST FAILED");
    $finish;
  end

endmodule

//--- flist.f
+incdir+.
demux_width_pkg.sv
demux_ctrl_pkg.sv
rd_id_table.sv
ar_route_gate.sv
r_resp_arbiter.sv
rd_demux_top.sv
tb_clk_gen.sv
rd_demux_assert.sv
rd_demux_tb.sv

//--- Bender.yml
package:
  name: rd_demux

export_include_dirs:
  - .

sources:
  - files:
      - demux_width_pkg.sv
      - demux_ctrl_pkg.sv
      - rd_id_table.sv
      - ar_route_gate.sv
      - r_resp_arbiter.sv
      - rd_demux_top.sv
  - target: test
    files:
      - tb_clk_gen.sv
      - rd_demux_assert.sv
      - rd_demux_tb.sv
